// File: files.f
+incdir+src
src/map_pkg.sv
src/snes_bus_pkg.sv
src/map_config_if.sv
src/map_config_regs.sv
src/cart_address_map.sv
src/peripheral_decode.sv
src/cart_mapper_top.sv
testbench/tb_cart_mapper.sv

// File: src/cart_address_map.sv
`timescale 1ns/1ns
`include "cart_defs.svh"

module cart_address_map (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr_early,
  input  logic                     snes_write_early,
  input  logic                     snes_romsel,
  map_config_if.sink               cfg,
  output snes_bus_pkg::snes_addr_t snes_addr,
  output snes_bus_pkg::snes_addr_t rom_addr,
  output logic                     rom_hit,
  output logic                     is_rom,
  output logic                     is_saveram,
  output logic                     is_writable
);
  import map_pkg::*;
  import snes_bus_pkg::*;

  logic [7:0]  mapper_dec;   // One-hot, indexed by mapper code
  logic        write_q;
  logic        romsel_q;
  logic        saveram_pre;
  logic        saveram_q;
  logic        map_known;
  logic        fx_open;
  logic        ex_open;
  logic        is_patch;
  bank_t       bank;
  region_t     region;
  snes_addr_t  sram_base_addr;
  snes_addr_t  sram_hi_addr;
  snes_addr_t  sram_lo_addr;
  snes_addr_t  hirom_addr;
  snes_addr_t  lorom_addr;
  snes_addr_t  exhirom_addr;
  snes_addr_t  menu_addr;

  //////////////////////////////
  // Mapper decode
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mapper_dec <= '0;
    end else begin
      mapper_dec <= 8'b1 << cfg.mapper;
    end
  end

  assign map_known = mapper_dec[MAP_HIROM] | mapper_dec[MAP_LOROM]
                   | mapper_dec[MAP_EXHIROM] | mapper_dec[MAP_MENU];

  // Save-RAM check runs a cycle early on the unregistered address
  always_comb begin
    saveram_pre = 1'b0;
    if (mapper_dec[MAP_HIROM] || mapper_dec[MAP_EXHIROM]) begin
      // Banks 20-3F and A0-BF, offsets 6000-7FFF
      saveram_pre = !snes_addr_early[22] && snes_addr_early[21]
                  && !snes_addr_early[15] && (&snes_addr_early[14:13]);
    end else if (mapper_dec[MAP_LOROM]) begin
      // Banks 70-7F and F0-FF, upper half only for small ROMs
      saveram_pre = (&snes_addr_early[22:20]) && !snes_romsel
                  && (!snes_addr_early[15] || !cfg.rom_mask[21]);
    end else if (mapper_dec[MAP_MENU]) begin
      saveram_pre = &snes_addr_early[23:20];  // Whole banks F0-FF
    end
    saveram_pre = saveram_pre && !cfg.unlock[`UNL_MAP] && cfg.saveram_mask[0];
  end

  //////////////////////////////
  // Address stage
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      snes_addr <= '0;
      write_q   <= 1'b0;
      romsel_q  <= 1'b1;
      saveram_q <= 1'b0;
    end else begin
      snes_addr <= snes_addr_early;
      write_q   <= snes_write_early;
      romsel_q  <= snes_romsel;
      saveram_q <= saveram_pre;
    end
  end

  assign bank   = snes_addr[23:16];
  assign region = bank[7:4];

  // Patch windows follow the bus direction of this access
  assign fx_open = cfg.unlock[`UNL_MAP]
                 | (cfg.unlock[`UNL_FX_RD] & write_q)
                 | (cfg.unlock[`UNL_FX_WR] & ~write_q);
  assign ex_open = (cfg.unlock[`UNL_EX_RD] & write_q)
                 | (cfg.unlock[`UNL_EX_WR] & ~write_q);

  assign is_patch = map_known
                  & ((fx_open & (region == 4'hF)) | (ex_open & (region == 4'hE)));

  //////////////////////////////
  // Translation
  //////////////////////////////

  assign sram_base_addr = `SRAM_REGION + {5'b0, cfg.saveram_base, 11'h0};
  assign sram_hi_addr   = sram_base_addr
                        + ({6'b0, snes_addr[20:16], snes_addr[12:0]} & cfg.saveram_mask);
  assign sram_lo_addr   = sram_base_addr
                        + ({4'b0, snes_addr[20:16], snes_addr[14:0]} & cfg.saveram_mask);

  assign hirom_addr   = {1'b0, snes_addr[22:0]} & cfg.rom_mask;
  assign lorom_addr   = {1'b0, ~snes_addr[23], snes_addr[22:16], snes_addr[14:0]}
                      & cfg.rom_mask;
  assign exhirom_addr = {1'b0, ~snes_addr[23], snes_addr[21:0]} & cfg.rom_mask;
  assign menu_addr    = hirom_addr + `MENU_ROM_BASE;

  always_comb begin
    if (!map_known) begin
      rom_addr = '0;
    end else if (is_patch) begin
      rom_addr = snes_addr;  // Patch sees raw bus address
    end else if (mapper_dec[MAP_HIROM]) begin
      rom_addr = saveram_q ? sram_hi_addr : hirom_addr;
    end else if (mapper_dec[MAP_LOROM]) begin
      rom_addr = saveram_q ? sram_lo_addr : lorom_addr;
    end else if (mapper_dec[MAP_EXHIROM]) begin
      rom_addr = saveram_q ? sram_hi_addr : exhirom_addr;
    end else begin
      rom_addr = saveram_q ? snes_addr : menu_addr;
    end
  end

  // Flags
  assign is_rom      = ~romsel_q;
  assign is_saveram  = saveram_q;
  assign is_writable = saveram_q | is_patch;
  assign rom_hit     = map_known & (is_rom | is_writable);

endmodule

// File: src/cart_defs.svh
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

//////////////////////////////
// Feature bits
//////////////////////////////

// Positions in the 16-bit feature word
`define FEAT_SRTC      2
`define FEAT_MSU1      3
`define FEAT_213F      4
`define FEAT_DMA1      11

//////////////////////////////
// Unlock bits
//////////////////////////////

`define UNL_MAP        0   // Full patch access to banks F0-FF
`define UNL_EX_RD      1
`define UNL_EX_WR      2
`define UNL_FX_RD      3
`define UNL_FX_WR      4

//////////////////////////////
// Memory layout
//////////////////////////////

`define SRAM_REGION    24'hE00000  // Save-RAM area in cartridge memory
`define MENU_ROM_BASE  24'hC00000  // Menu image sits in upper memory

// Peripheral register windows, offsets within a bank
`define MSU_BASE       16'h2000
`define DMA_BASE       16'h2020
`define SRTC_BASE      16'h2800
`define EXE_ADDR       16'h2C00
`define MAP_ADDR       16'h2BB2
`define SNESCMD_LO     16'h2A00
`define SNESCMD_HI     16'h2FFF

// Exact bus addresses
`define NMICMD_ADDR    24'h002BF2
`define RETVEC_ADDR    24'h002A6C

// B-bus port addresses
`define PA_213F        8'h3F
`define PA_2100        8'h00

`endif

// File: src/cart_mapper_top.sv
`timescale 1ns/1ns

module cart_mapper_top (
  input  logic                     CLK,
  input  logic                     rst_n,
  // MCU write port
  input  logic                     cfg_we,
  input  map_pkg::cfg_reg_e        cfg_sel,
  input  logic [7:0]               cfg_data,
  // Console bus
  input  snes_bus_pkg::snes_addr_t snes_addr_early,
  input  logic                     snes_write_early,
  input  logic                     snes_romsel,
  input  logic [7:0]               snes_pa,
  // Memory side
  output snes_bus_pkg::snes_addr_t rom_addr,
  output logic                     rom_hit,
  output logic                     is_rom,
  output logic                     is_saveram,
  output logic                     is_writable,
  // Peripheral enables
  output logic                     msu_enable,
  output logic                     dma_enable,
  output logic                     srtc_enable,
  output logic                     exe_enable,
  output logic                     map_enable,
  output logic                     snescmd_enable,
  output logic                     nmicmd_enable,
  output logic                     return_vector_enable,
  output logic                     r213f_enable,
  output logic                     r2100_enable
);
  import snes_bus_pkg::*;

  snes_addr_t   snes_addr_q;  // Shared address stage
  periph_sel_t  periph;

  map_config_if cfg_bus ();

  map_config_regs u_regs (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg      (cfg_bus)
  );

  cart_address_map u_addr_map (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .snes_addr_early  (snes_addr_early),
    .snes_write_early (snes_write_early),
    .snes_romsel      (snes_romsel),
    .cfg              (cfg_bus),
    .snes_addr        (snes_addr_q),
    .rom_addr         (rom_addr),
    .rom_hit          (rom_hit),
    .is_rom           (is_rom),
    .is_saveram       (is_saveram),
    .is_writable      (is_writable)
  );

  peripheral_decode u_periph (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .snes_addr (snes_addr_q),
    .snes_pa   (snes_pa),
    .cfg       (cfg_bus),
    .periph    (periph)
  );

  //////////////////////////////
  // Enable bits out
  //////////////////////////////

  assign msu_enable           = periph.msu;
  assign dma_enable           = periph.dma;
  assign srtc_enable          = periph.srtc;
  assign exe_enable           = periph.exe;
  assign map_enable           = periph.map;
  assign snescmd_enable       = periph.snescmd;
  assign nmicmd_enable        = periph.nmicmd;
  assign return_vector_enable = periph.return_vector;
  assign r213f_enable         = periph.r213f;
  assign r2100_enable         = periph.r2100;

endmodule

// File: src/map_config_if.sv
`timescale 1ns/1ns

interface map_config_if;
  import map_pkg::*;

  mapper_e      mapper;
  logic [7:0]   saveram_base;   // In 2 KB steps
  logic [23:0]  saveram_mask;
  logic [23:0]  rom_mask;
  logic [15:0]  featurebits;
  logic [4:0]   unlock;

  // Register file side
  modport source (
    output mapper,
    output saveram_base,
    output saveram_mask,
    output rom_mask,
    output featurebits,
    output unlock
  );

  // Decoder side
  modport sink (
    input mapper,
    input saveram_base,
    input saveram_mask,
    input rom_mask,
    input featurebits,
    input unlock
  );

endinterface

// File: src/map_config_regs.sv
`timescale 1ns/1ns

module map_config_regs (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               cfg_we,
  input  map_pkg::cfg_reg_e  cfg_sel,
  input  logic [7:0]         cfg_data,
  map_config_if.source       cfg
);
  import map_pkg::*;

  mapper_e          mapper_q;
  logic [7:0]       sram_base_q;
  logic [2:0][7:0]  sram_mask_q;  // Byte 0 is bits 7:0
  logic [2:0][7:0]  rom_mask_q;
  logic [1:0][7:0]  feat_q;
  logic [4:0]       unlock_q;

  //////////////////////////////
  // Byte writes from the MCU
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mapper_q    <= MAP_HIROM;
      sram_base_q <= '0;
      sram_mask_q <= '0;
      rom_mask_q  <= '0;
      feat_q      <= '0;
      unlock_q    <= '0;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_MAPPER: begin
          mapper_q <= mapper_e'(cfg_data[2:0]);  // Upper bits ignored
        end
        CFG_SRAM_BASE:  sram_base_q    <= cfg_data;
        CFG_SRAM_MASK0: sram_mask_q[0] <= cfg_data;
        CFG_SRAM_MASK1: sram_mask_q[1] <= cfg_data;
        CFG_SRAM_MASK2: sram_mask_q[2] <= cfg_data;
        CFG_ROM_MASK0:  rom_mask_q[0]  <= cfg_data;
        CFG_ROM_MASK1:  rom_mask_q[1]  <= cfg_data;
        CFG_ROM_MASK2:  rom_mask_q[2]  <= cfg_data;
        CFG_FEAT0:      feat_q[0]      <= cfg_data;
        CFG_FEAT1:      feat_q[1]      <= cfg_data;
        CFG_UNLOCK:     unlock_q       <= cfg_data[4:0];
        default: begin
          // Spare index, write dropped
        end
      endcase
    end
  end

  //////////////////////////////
  // Out to the decoders
  //////////////////////////////

  assign cfg.mapper       = mapper_q;
  assign cfg.saveram_base = sram_base_q;
  assign cfg.saveram_mask = sram_mask_q;
  assign cfg.rom_mask     = rom_mask_q;
  assign cfg.featurebits  = feat_q;
  assign cfg.unlock       = unlock_q;

endmodule

// File: src/map_pkg.sv
package map_pkg;

  //////////////////////////////
  // Mapper modes
  //////////////////////////////

  // Codes match the MCU side mapper detection
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,  // 48-64 Mbit images
    MAP_MENU    = 3'd7   // Menu ROM in upper memory
  } mapper_e;

  //////////////////////////////
  // Config register indices
  //////////////////////////////

  // One byte per index
  typedef enum logic [3:0] {
    CFG_MAPPER     = 4'd0,
    CFG_SRAM_BASE  = 4'd1,
    CFG_SRAM_MASK0 = 4'd2,   // Bits 7:0
    CFG_SRAM_MASK1 = 4'd3,   // Bits 15:8
    CFG_SRAM_MASK2 = 4'd4,   // Bits 23:16
    CFG_ROM_MASK0  = 4'd5,
    CFG_ROM_MASK1  = 4'd6,
    CFG_ROM_MASK2  = 4'd7,
    CFG_FEAT0      = 4'd8,   // Feature bits 7:0
    CFG_FEAT1      = 4'd9,   // Feature bits 15:8
    CFG_UNLOCK     = 4'd10
  } cfg_reg_e;

  // Indices 11 to 15 are spare

endpackage

// File: src/peripheral_decode.sv
`timescale 1ns/1ns
`include "cart_defs.svh"

module peripheral_decode (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  snes_bus_pkg::snes_addr_t  snes_addr,
  input  logic [7:0]                snes_pa,
  map_config_if.sink                cfg,
  output snes_bus_pkg::periph_sel_t periph
);
  import snes_bus_pkg::*;

  logic [7:0]  pa_q;      // Lines up with the registered address
  offset_t     offset;
  logic        low_half;  // A22 clear, system area mirror

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pa_q <= 8'hFF;  // Idle port, no register selected
    end else begin
      pa_q <= snes_pa;
    end
  end

  assign offset   = snes_addr[15:0];
  assign low_half = ~snes_addr[22];

  //////////////////////////////
  // A-bus windows
  //////////////////////////////

  always_comb begin
    periph.msu  = cfg.featurebits[`FEAT_MSU1] & low_half
                & ((offset & 16'hFFF8) == `MSU_BASE);
    periph.dma  = (cfg.featurebits[`FEAT_DMA1] | cfg.unlock[`UNL_MAP]) & low_half
                & ((offset & 16'hFFF0) == `DMA_BASE);
    periph.srtc = cfg.featurebits[`FEAT_SRTC] & low_half
                & ((offset & 16'hFFFE) == `SRTC_BASE);
    periph.exe  = low_half & (offset == `EXE_ADDR);
    periph.map  = low_half & (offset == `MAP_ADDR);

    // Command area 2A00-2FFF
    periph.snescmd = low_half & (offset >= `SNESCMD_LO) & (offset <= `SNESCMD_HI);

    // Full address match
    periph.nmicmd        = (snes_addr == `NMICMD_ADDR);
    periph.return_vector = (snes_addr == `RETVEC_ADDR);

    //////////////////////////////
    // B-bus ports
    //////////////////////////////

    periph.r213f = cfg.featurebits[`FEAT_213F] & (pa_q == `PA_213F);
    periph.r2100 = (pa_q == `PA_2100);  // PPU brightness register
  end

endmodule

// File: src/snes_bus_pkg.sv
package snes_bus_pkg;

  // Bus address and cartridge memory address share one width
  typedef logic [23:0] snes_addr_t;

  //////////////////////////////
  // Bank helpers
  //////////////////////////////

  typedef logic [7:0]  bank_t;      // A23..A16
  typedef logic [3:0]  region_t;    // Upper bank nibble
  typedef logic [15:0] offset_t;    // A15..A0

  //////////////////////////////
  // Peripheral selects
  //////////////////////////////

  typedef struct packed {
    logic msu;
    logic dma;
    logic srtc;
    logic exe;
    logic map;
    logic snescmd;
    logic nmicmd;
    logic return_vector;
    logic r213f;
    logic r2100;
  } periph_sel_t;

endpackage

// File: testbench/tb_cart_mapper.sv
`timescale 1ns/1ns
`include "cart_defs.svh"

module tb_cart_mapper;
  import map_pkg::*;

  localparam int TIMEOUT_CYCLES = 5000;

  typedef struct packed {
    logic [23:0] addr;
    logic        hit;
    logic        rom;
    logic        sram;
    logic        wr;
    logic [9:0]  periph;  // msu down to r2100
  } expect_t;

  logic        CLK;
  logic        rst_n;
  logic        cfg_we;
  cfg_reg_e    cfg_sel;
  logic [7:0]  cfg_data;
  logic [23:0] snes_addr_early;
  logic        snes_write_early;
  logic        snes_romsel;
  logic [7:0]  snes_pa;
  logic [23:0] rom_addr;
  logic        rom_hit;
  logic        is_rom;
  logic        is_saveram;
  logic        is_writable;
  logic [9:0]  periph;

  integer      seed = 32'h88ad_348f;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          checks_mark;
  int          errors_mark;

  // Copy of what was last written to the config registers
  logic [2:0]  cfg_mapper;
  logic [7:0]  cfg_base;
  logic [23:0] cfg_sram_mask;
  logic [23:0] cfg_rom_mask;
  logic [15:0] cfg_feat;
  logic [4:0]  cfg_unlock;

  logic [23:0] corners [12] = '{24'h206000, 24'h3F7FFF, 24'hA06000, 24'hBF7FFF,
                                24'h205FFF, 24'h008000, 24'h700000, 24'h7F7FFF,
                                24'hF00000, 24'hFFFFFF, 24'hE08000, 24'hC00000};
  logic [23:0] windows [13] = '{24'h002000, 24'h002007, 24'h002008, 24'h002020,
                                24'h00202F, 24'h002800, 24'h002801, 24'h002C00,
                                24'h002BB2, 24'h002A00, 24'h002FFF, 24'h002BF2,
                                24'h002A6C};
  string       periph_names [10] = '{"msu_enable", "dma_enable", "srtc_enable",
                                     "exe_enable", "map_enable", "snescmd_enable",
                                     "nmicmd_enable", "return_vector_enable",
                                     "r213f_enable", "r2100_enable"};

  cart_mapper_top DUT (
    .*,
    .msu_enable           (periph[9]),
    .dma_enable           (periph[8]),
    .srtc_enable          (periph[7]),
    .exe_enable           (periph[6]),
    .map_enable           (periph[5]),
    .snescmd_enable       (periph[4]),
    .nmicmd_enable        (periph[3]),
    .return_vector_enable (periph[2]),
    .r213f_enable         (periph[1]),
    .r2100_enable         (periph[0])
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic expect_t model(input logic [23:0] a, input logic wr,
                                    input logic romsel, input logic [7:0] pa);
    expect_t     e;
    logic        known;
    logic        sram;
    logic        fx;
    logic        ex;
    logic        patch;
    logic        lo;
    logic [15:0] o;
    logic [23:0] base;
    known = 1'b1;
    case (cfg_mapper)
      3'd0, 3'd2: sram = !a[22] && a[21] && (a[15:13] == 3'b011);
      3'd1:       sram = (&a[22:20]) && !romsel && (!a[15] || !cfg_rom_mask[21]);
      3'd7:       sram = &a[23:20];
      default: begin
        known = 1'b0;
        sram  = 1'b0;
      end
    endcase
    sram  = sram && !cfg_unlock[`UNL_MAP] && cfg_sram_mask[0];
    fx    = cfg_unlock[`UNL_MAP] || (cfg_unlock[`UNL_FX_RD] && wr)
         || (cfg_unlock[`UNL_FX_WR] && !wr);
    ex    = (cfg_unlock[`UNL_EX_RD] && wr) || (cfg_unlock[`UNL_EX_WR] && !wr);
    patch = known && ((fx && a[23:20] == 4'hF) || (ex && a[23:20] == 4'hE));
    base  = `SRAM_REGION + cfg_base * 24'h800;
    if (!known) begin
      e.addr = '0;
    end else if (patch) begin
      e.addr = a;
    end else if (cfg_mapper == 3'd1) begin
      e.addr = sram ? base + ({4'b0, a[20:16], a[14:0]} & cfg_sram_mask)
                    : {1'b0, ~a[23], a[22:16], a[14:0]} & cfg_rom_mask;
    end else if (cfg_mapper == 3'd7) begin
      e.addr = sram ? a : ({1'b0, a[22:0]} & cfg_rom_mask) + `MENU_ROM_BASE;
    end else if (sram) begin
      e.addr = base + ({6'b0, a[20:16], a[12:0]} & cfg_sram_mask);
    end else if (cfg_mapper == 3'd2) begin
      e.addr = {1'b0, ~a[23], a[21:0]} & cfg_rom_mask;
    end else begin
      e.addr = {1'b0, a[22:0]} & cfg_rom_mask;
    end
    e.sram = sram;
    e.wr   = sram || patch;
    e.rom  = !romsel;
    e.hit  = known && (!romsel || e.wr);
    lo = !a[22];
    o  = a[15:0];
    e.periph[9] = cfg_feat[`FEAT_MSU1] && lo && o >= 16'h2000 && o <= 16'h2007;
    e.periph[8] = (cfg_feat[`FEAT_DMA1] || cfg_unlock[`UNL_MAP]) && lo
               && o >= 16'h2020 && o <= 16'h202F;
    e.periph[7] = cfg_feat[`FEAT_SRTC] && lo && o >= 16'h2800 && o <= 16'h2801;
    e.periph[6] = lo && o == 16'h2C00;
    e.periph[5] = lo && o == 16'h2BB2;
    e.periph[4] = lo && o >= 16'h2A00 && o <= 16'h2FFF;
    e.periph[3] = (a == 24'h002BF2);
    e.periph[2] = (a == 24'h002A6C);
    e.periph[1] = cfg_feat[`FEAT_213F] && pa == 8'h3F;
    e.periph[0] = (pa == 8'h00);
    return e;
  endfunction

  // ROM area is A15 high or A22 high
  function automatic logic romsel_for(input logic [23:0] a);
    return !(a[22] || a[15]);
  endfunction

  //////////////////////////////
  // Driver and checks
  //////////////////////////////

  task automatic check_value(input string name, input logic [23:0] exp,
                             input logic [23:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_outputs(input expect_t e);
    int i;
    check_value("rom_addr", e.addr, rom_addr);
    check_value("rom_hit", e.hit, rom_hit);
    check_value("is_rom", e.rom, is_rom);
    check_value("is_saveram", e.sram, is_saveram);
    check_value("is_writable", e.wr, is_writable);
    for (i = 0; i < 10; i++) begin
      check_value(periph_names[i], e.periph[9 - i], periph[9 - i]);
    end
  endtask

  task automatic write_cfg(input cfg_reg_e sel, input logic [7:0] data);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    @(negedge CLK);
    cfg_we   = 1'b0;
  endtask

  task automatic set_config(input logic [2:0] m, input logic [23:0] rmask,
                            input logic [23:0] smask, input logic [7:0] base,
                            input logic [15:0] feat, input logic [4:0] unl);
    cfg_mapper    = m;
    cfg_rom_mask  = rmask;
    cfg_sram_mask = smask;
    cfg_base      = base;
    cfg_feat      = feat;
    cfg_unlock    = unl;
    write_cfg(CFG_MAPPER, {5'b0, m});
    write_cfg(CFG_SRAM_BASE, base);
    write_cfg(CFG_SRAM_MASK0, smask[7:0]);
    write_cfg(CFG_SRAM_MASK1, smask[15:8]);
    write_cfg(CFG_SRAM_MASK2, smask[23:16]);
    write_cfg(CFG_ROM_MASK0, rmask[7:0]);
    write_cfg(CFG_ROM_MASK1, rmask[15:8]);
    write_cfg(CFG_ROM_MASK2, rmask[23:16]);
    write_cfg(CFG_FEAT0, feat[7:0]);
    write_cfg(CFG_FEAT1, feat[15:8]);
    write_cfg(CFG_UNLOCK, {3'b0, unl});
    repeat (3) @(negedge CLK);  // Mapper decode is registered
  endtask

  // Starts on a falling edge and checks on the next one
  task automatic access(input logic [23:0] a, input logic wr, input logic romsel,
                        input logic [7:0] pa);
    expect_t e;
    snes_addr_early  = a;
    snes_write_early = wr;
    snes_romsel      = romsel;
    snes_pa          = pa;
    e = model(a, wr, romsel, pa);
    @(negedge CLK);
    check_outputs(e);
  endtask

  task automatic run_corners(input logic wr);
    int i;
    for (i = 0; i < 12; i++) begin
      access(corners[i], wr, romsel_for(corners[i]), 8'hFF);
    end
  endtask

  // One access per cycle back to back
  task automatic random_accesses(input int n);
    logic [31:0] r;
    int          i;
    for (i = 0; i < n; i++) begin
      r = $random(seed);
      access(r[23:0], r[24], romsel_for(r[23:0]), {2'b00, r[31:26]});
    end
  endtask

  task automatic start_test();
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic end_test(input string name);
    $display("%-12s %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    start_test();
    check_outputs('0);
    end_test("reset");
  endtask

  task automatic test_hirom();
    start_test();
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h03, 16'h0000, 5'h00);
    run_corners(1'b0);
    random_accesses(40);
    // Save-RAM stays off while mask bit 0 is clear
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFE, 8'h03, 16'h0000, 5'h00);
    run_corners(1'b0);
    set_config(MAP_EXHIROM, 24'h7FFFFF, 24'h003FFF, 8'h10, 16'h0000, 5'h00);
    run_corners(1'b0);
    random_accesses(40);
    end_test("hirom");
  endtask

  task automatic test_lorom();
    start_test();
    set_config(MAP_LOROM, 24'h1FFFFF, 24'h007FFF, 8'h00, 16'h0000, 5'h00);
    run_corners(1'b0);
    // Save-RAM banks need romsel low
    access(24'h700000, 1'b0, 1'b1, 8'hFF);
    access(24'hF07FFF, 1'b1, 1'b1, 8'hFF);
    random_accesses(40);
    set_config(MAP_LOROM, 24'h3FFFFF, 24'h01FFFF, 8'h20, 16'h0000, 5'h00);
    run_corners(1'b1);
    random_accesses(40);
    end_test("lorom");
  endtask

  task automatic test_menu_patch();
    start_test();
    set_config(MAP_MENU, 24'h0FFFFF, 24'h01FFFF, 8'h00, 16'h0000, 5'h00);
    run_corners(1'b0);
    random_accesses(40);
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h02, 16'h0000, 5'b00001);
    run_corners(1'b0);
    random_accesses(30);
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h02, 16'h0000, 5'b01000);
    run_corners(1'b0);
    run_corners(1'b1);
    set_config(MAP_LOROM, 24'h3FFFFF, 24'h00FFFF, 8'h01, 16'h0000, 5'b10110);
    run_corners(1'b0);
    run_corners(1'b1);
    random_accesses(30);
    set_config(3'd4, 24'hFFFFFF, 24'hFFFFFF, 8'h00, 16'h0000, 5'h00);  // Unknown mode
    run_corners(1'b0);
    end_test("menu_patch");
  endtask

  task automatic peripheral_sweep();
    int i;
    for (i = 0; i < 13; i++) begin
      access(windows[i], 1'b0, 1'b1, 8'hFF);
      access(windows[i] | 24'h400000, 1'b0, 1'b1, 8'hFF);
    end
    access(24'h000000, 1'b0, 1'b1, 8'h3F);
    access(24'h000000, 1'b0, 1'b1, 8'h00);
    access(24'h000000, 1'b0, 1'b1, 8'h3E);
  endtask

  task automatic test_peripherals();
    start_test();
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h00, 16'h0000, 5'h00);
    peripheral_sweep();
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h00, 16'h081C, 5'h00);
    peripheral_sweep();
    set_config(MAP_HIROM, 24'h3FFFFF, 24'h001FFF, 8'h00, 16'h0000, 5'b00001);
    peripheral_sweep();  // DMA opened by the map unlock
    end_test("peripherals");
  endtask

  task automatic test_pipeline();
    start_test();
    set_config(MAP_LOROM, 24'h3FFFFF, 24'h00FFFF, 8'h05, 16'h081C, 5'b01010);
    random_accesses(120);
    end_test("pipeline");
  endtask

  initial begin
    rst_n            = 1'b0;
    cfg_we           = 1'b0;
    cfg_sel          = CFG_MAPPER;
    cfg_data         = 8'h00;
    snes_addr_early  = 24'h000000;
    snes_write_early = 1'b0;
    snes_romsel      = 1'b1;
    snes_pa          = 8'hFF;
    cfg_mapper       = 3'd0;
    cfg_base         = 8'h00;
    cfg_sram_mask    = 24'h0;
    cfg_rom_mask     = 24'h0;
    cfg_feat         = 16'h0;
    cfg_unlock       = 5'h0;
    repeat (8) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    test_reset();
    test_hirom();
    test_lorom();
    test_menu_patch();
    test_peripherals();
    test_pipeline();
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
